//--- common/rv_consts.svh
/* Global sizing macros and default fault-catch switch */

`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// Data and address width
`define RV_XLEN 32

// Architectural register count, x0 included
`define RV_NREGS 32

`define RV_CATCH_DEFAULT 1 // Fault detection on by default

`endif

//--- common/rv_isa_pkg.sv
/* RV32I encoding types: major opcodes, branch conditions, access sizes,
   register index type and the immediate extractor */

package rv_isa_pkg;

  // Major opcode, instruction bits 6:2
  typedef enum logic [4:0] {
    LOAD   = 5'b00000,
    MISC   = 5'b00011, // FENCE, FENCE.I
    OPIMM  = 5'b00100,
    AUIPC  = 5'b00101,
    STORE  = 5'b01000,
    OP     = 5'b01100,
    LUI    = 5'b01101,
    BRANCH = 5'b11000,
    JALR   = 5'b11001,
    JAL    = 5'b11011,
    SYSTEM = 5'b11100
  } opcode_e;

  // Branch funct3, 2 and 3 unused
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branch_e;

  typedef enum logic [1:0] {
    BYTE = 2'b00,
    HALF = 2'b01,
    WORD = 2'b10
  } size_e; // funct3[1:0] of loads and stores

  typedef logic [4:0] regsel_t; // Register index

  // Sign-extended immediate, format picked from the opcode
  function automatic logic [31:0] imm_extract(input logic [31:0] ir);
    logic [31:0] imm;
    case (opcode_e'(ir[6:2]))
      LUI, AUIPC: imm = {ir[31:12], 12'b0};                               // U
      JAL:        imm = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0}; // J
      BRANCH:     imm = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};   // B
      STORE:      imm = {{21{ir[31]}}, ir[30:25], ir[11:7]};                // S
      default:    imm = {{21{ir[31]}}, ir[30:20]};                          // I
    endcase
    return imm;
  endfunction

endpackage

//--- common/rv_ex_pkg.sv
/* Types handed from decode to execute: ALU operation and system operation */

package rv_ex_pkg;

  // ALU opcode, {funct7[5], funct3}
  typedef enum logic [3:0] {
    ADD  = 4'b0000,
    SLL  = 4'b0001,
    SLT  = 4'b0010,
    SLTU = 4'b0011,
    XOR  = 4'b0100,
    SRL  = 4'b0101,
    OR   = 4'b0110,
    AND  = 4'b0111,
    SUB  = 4'b1000,
    SRA  = 4'b1101
  } alu_op_e;

  typedef enum logic [1:0] {
    ECALL  = 2'd0,
    EBREAK = 2'd1,
    MRET   = 2'd2,
    WFI    = 2'd3 // Treated as a hint by execute
  } sys_op_e;

endpackage

//--- rtl/reg_file.sv
/* Integer register file, two read ports and one write port with bypass */

`timescale 1ns/1ps
`include "rv_consts.svh"

module reg_file
  import rv_isa_pkg::*;
(
  input  logic                clk,
  input  logic                rstz,
  input  regsel_t             rs1_sel,
  input  regsel_t             rs2_sel,
  input  logic                regwr_en,
  input  regsel_t             regwr_sel,
  input  logic [`RV_XLEN-1:0] regwr_data,
  output logic [`RV_XLEN-1:0] rs1_data,
  output logic [`RV_XLEN-1:0] rs2_data
);

  logic [`RV_XLEN-1:0] regs [1:`RV_NREGS-1]; // No storage behind x0

  // One read port: x0 reads zero, then same-cycle write wins
  function automatic logic [`RV_XLEN-1:0] read_port(input regsel_t sel);
    logic [`RV_XLEN-1:0] val;
    if (sel == '0) val = '0;
    else if (regwr_en && regwr_sel == sel) val = regwr_data; // Bypass
    else val = regs[sel];
    return val;
  endfunction

  // ------------------------------
  // Write port
  always_ff @(posedge clk or negedge rstz) begin
    if (!rstz) begin
      for (int i = 1; i < `RV_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (regwr_en && regwr_sel != '0) begin // x0 writes dropped
      regs[regwr_sel] <= regwr_data;
    end
  end

  // ------------------------------
  // Read ports
  always_comb begin
    rs1_data = read_port(rs1_sel);
    rs2_data = read_port(rs2_sel);
  end

endmodule

//--- rtl/addr_gen.sv
/* Address generator for jump, branch and load/store targets,
   with target and access alignment checks */

`timescale 1ns/1ps
`include "rv_consts.svh"

module addr_gen
  import rv_isa_pkg::*;
#(
  parameter CATCH_MISALIGNED_JMP  = `RV_CATCH_DEFAULT,
  parameter CATCH_MISALIGNED_LDST = `RV_CATCH_DEFAULT
)(
  input  logic [`RV_XLEN-1:0] instr,
  input  logic [`RV_XLEN-1:0] pc,
  input  logic [`RV_XLEN-1:0] rs1_data,
  output logic [`RV_XLEN-1:0] addr,
  output logic                misaligned_jmp,
  output logic                misaligned_ldst
);

  opcode_e             opc;
  size_e               size;
  logic [`RV_XLEN-1:0] base, offset, sum;
  logic                ldst_odd;

  assign opc  = opcode_e'(instr[6:2]);
  assign size = size_e'(instr[13:12]);

  // Base and offset per opcode, pc + 4 otherwise
  always_comb begin
    base   = pc;
    offset = `RV_XLEN'd4;
    case (opc)
      JAL, BRANCH: offset = imm_extract(instr); // pc relative
      JALR, LOAD, STORE: begin                  // rs1 relative
        base   = rs1_data;
        offset = imm_extract(instr);
      end
      default: offset = `RV_XLEN'd4;
    endcase
  end

  assign sum  = base + offset;
  assign addr = (opc == JALR) ? {sum[`RV_XLEN-1:1], 1'b0} : sum; // JALR drops bit 0

  // Access alignment, bytes never fault
  assign ldst_odd = (size == HALF && addr[0]) || (size == WORD && addr[1:0] != 2'b00);

  assign misaligned_jmp  = (CATCH_MISALIGNED_JMP != 0) && (opc inside {JAL, JALR, BRANCH})
                           && addr[1];
  assign misaligned_ldst = (CATCH_MISALIGNED_LDST != 0) && (opc inside {LOAD, STORE})
                           && ldst_odd;

endmodule

//--- rtl/branch_compare.sv
/* Branch condition evaluation for the six RV32I branches */

`timescale 1ns/1ps
`include "rv_consts.svh"

module branch_compare
  import rv_isa_pkg::*;
(
  input  logic [`RV_XLEN-1:0] instr,
  input  logic [`RV_XLEN-1:0] rs1_data,
  input  logic [`RV_XLEN-1:0] rs2_data,
  output logic                taken
);

  branch_e cond;
  logic    eq, lt, ltu;

  assign cond = branch_e'(instr[14:12]);
  assign eq   = rs1_data == rs2_data;
  assign lt   = $signed(rs1_data) < $signed(rs2_data);
  assign ltu  = rs1_data < rs2_data;

  always_comb begin
    case (cond)
      BEQ:     taken = eq;
      BNE:     taken = !eq;
      BLT:     taken = lt;
      BGE:     taken = !lt;
      BLTU:    taken = ltu;
      BGEU:    taken = !ltu;
      default: taken = 1'b0; // Reserved encodings
    endcase
  end

endmodule

//--- decode/instr_decoder.sv
/* Instruction decoder: legality check, ALU operands, store data and mask,
   and the registered decode slot with its valid/ready handshake */

`timescale 1ns/1ps
`include "rv_consts.svh"

module instr_decoder
  import rv_isa_pkg::*;
  import rv_ex_pkg::*;
#(
  parameter CATCH_ILLEGAL_INSTR = `RV_CATCH_DEFAULT
)(
  input  logic                clk,
  input  logic                rstz,
  input  logic                flush,
  input  logic [`RV_XLEN-1:0] fetch_pc,
  input  logic [`RV_XLEN-1:0] fetch_ir,
  input  logic                fetch_vld,
  output logic                fetch_rdy,
  input  logic                decode_rdy,
  input  logic [`RV_XLEN-1:0] rs1_data,
  input  logic [`RV_XLEN-1:0] rs2_data,
  input  logic [`RV_XLEN-1:0] addr,
  input  logic                misaligned_jmp,
  input  logic                misaligned_ldst,
  input  logic                taken,
  output logic                decode_vld,
  output logic [`RV_XLEN-1:0] decode_pc,
  output logic [`RV_XLEN-1:0] decode_ir,
  output alu_op_e             decode_aluop,
  output logic [`RV_XLEN-1:0] decode_op1,
  output logic [`RV_XLEN-1:0] decode_op2,
  output logic                decode_regwr,
  output logic [`RV_XLEN-1:0] decode_addr,
  output logic [3:0]          decode_mask,
  output logic                decode_jump,
  output logic                decode_branch,
  output logic                decode_load,
  output logic                decode_store,
  output logic                decode_csr,
  output logic                decode_system,
  output sys_op_e             decode_sysop,
  output logic                decode_illegal,
  output logic                decode_misaligned_jmp,
  output logic                decode_misaligned_ldst
);

  opcode_e             opc;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  regsel_t             rs1, rd;
  logic [`RV_XLEN-1:0] imm, store_data, op1, op2;
  logic [3:0]          mask;
  alu_op_e             aluop;
  sys_op_e             sysop;
  logic                instr_valid, is_fencei, csr, illegal, regwr, accept;

  // Instruction fields
  assign opc    = opcode_e'(fetch_ir[6:2]);
  assign funct3 = fetch_ir[14:12];
  assign funct7 = fetch_ir[31:25];
  assign rs1    = fetch_ir[19:15];
  assign rd     = fetch_ir[11:7];
  assign imm    = imm_extract(fetch_ir);

  // ------------------------------
  // Store data and byte mask
  always_comb begin
    case (addr[1:0]) // Rotate left by byte offset
      2'd0:    store_data = rs2_data;
      2'd1:    store_data = {rs2_data[23:0], rs2_data[31:24]};
      2'd2:    store_data = {rs2_data[15:0], rs2_data[31:16]};
      default: store_data = {rs2_data[7:0], rs2_data[31:8]};
    endcase
    if (opc == STORE && size_e'(funct3[1:0]) == BYTE) mask = 4'h1 << addr[1:0];
    else if (opc == STORE && size_e'(funct3[1:0]) == HALF) mask = addr[1] ? 4'hC : 4'h3;
    else mask = 4'hF;
  end

  // ------------------------------
  // Operation decode and legality
  always_comb begin
    op1         = fetch_pc; // pc + 4 by default
    op2         = `RV_XLEN'd4;
    aluop       = ADD;
    sysop       = ECALL;
    csr         = 1'b0;
    is_fencei   = 1'b0;
    instr_valid = 1'b0;
    case (opc)
      LUI: begin
        op1         = '0;
        op2         = imm;
        instr_valid = 1'b1;
      end
      AUIPC: begin
        op2         = imm;
        instr_valid = 1'b1;
      end
      JAL:    instr_valid = 1'b1;               // Link value pc + 4
      JALR:   instr_valid = funct3 == 3'b000;
      BRANCH: instr_valid = funct3 inside {3'b000, 3'b001, [3'b100:3'b111]};
      LOAD:   instr_valid = funct3 inside {[3'b000:3'b010], 3'b100, 3'b101};
      STORE: begin
        op2         = store_data;
        instr_valid = funct3 inside {[3'b000:3'b010]};
      end
      OPIMM: begin
        op1 = rs1_data;
        op2 = imm;
        // Only shifts carry funct7[5]
        aluop = alu_op_e'({(funct3[1:0] == 2'b01) & funct7[5], funct3});
        if (funct3 == 3'b001) instr_valid = funct7 == 7'h00;
        else if (funct3 == 3'b101) instr_valid = funct7 == 7'h00 || funct7 == 7'h20;
        else instr_valid = 1'b1;
      end
      OP: begin
        op1         = rs1_data;
        op2         = rs2_data;
        aluop       = alu_op_e'({funct7[5], funct3});
        instr_valid = funct7 == 7'h00
                      || (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101));
      end
      MISC: begin
        is_fencei   = funct3 == 3'b001;           // Refetch via jump to pc + 4
        instr_valid = funct3 inside {3'b000, 3'b001}; // FENCE is a NOP
      end
      SYSTEM: begin
        if (funct3 == 3'b000) begin
          instr_valid = rs1 == '0 && rd == '0;
          case (fetch_ir[31:20])
            12'h000: sysop = ECALL;
            12'h001: sysop = EBREAK;
            12'h302: sysop = MRET;
            12'h105: sysop = WFI;
            default: instr_valid = 1'b0;
          endcase
        end else if (funct3 != 3'b100) begin // CSR access
          csr         = 1'b1;
          op1         = funct3[2] ? {27'b0, rs1} : rs1_data; // uimm or rs1
          instr_valid = 1'b1;
        end
      end
      default: instr_valid = 1'b0;
    endcase
  end

  assign illegal = (CATCH_ILLEGAL_INSTR != 0) && (!instr_valid || fetch_ir[1:0] != 2'b11);
  assign regwr   = rd != '0 && (opc inside {LUI, AUIPC, JAL, JALR, OPIMM, OP}); // ALU results

  // ------------------------------
  // Output slot and handshake
  assign fetch_rdy = !decode_vld || decode_rdy;
  assign accept    = fetch_vld && fetch_rdy && !flush;

  always_ff @(posedge clk or negedge rstz) begin
    if (!rstz) decode_vld <= 1'b0;
    else if (flush) decode_vld <= 1'b0;
    else if (accept) decode_vld <= 1'b1;
    else if (decode_rdy) decode_vld <= 1'b0; // Consumed, nothing new
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      decode_pc              <= fetch_pc;
      decode_ir              <= fetch_ir;
      decode_aluop           <= aluop;
      decode_op1             <= op1;
      decode_op2             <= op2;
      decode_regwr           <= regwr;
      decode_addr            <= addr;
      decode_mask            <= mask;
      decode_jump            <= opc == JAL || opc == JALR || is_fencei;
      decode_branch          <= taken && opc == BRANCH;
      decode_load            <= opc == LOAD;
      decode_store           <= opc == STORE;
      decode_csr             <= csr;
      decode_system          <= opc == SYSTEM && !csr;
      decode_sysop           <= sysop;
      decode_illegal         <= illegal;
      decode_misaligned_jmp  <= misaligned_jmp;
      decode_misaligned_ldst <= misaligned_ldst;
    end
  end

endmodule

//--- decode/decode_stage.sv
/* Decode stage top: register file, address generator, branch comparator
   and instruction decoder */

`timescale 1ns/1ps
`include "rv_consts.svh"

module decode_stage
  import rv_isa_pkg::*;
  import rv_ex_pkg::*;
#(
  parameter CATCH_ILLEGAL_INSTR   = `RV_CATCH_DEFAULT,
  parameter CATCH_MISALIGNED_JMP  = `RV_CATCH_DEFAULT,
  parameter CATCH_MISALIGNED_LDST = `RV_CATCH_DEFAULT
)(
  input  logic                clk,
  input  logic                rstz,
  input  logic                flush,
  // Fetch side
  input  logic [`RV_XLEN-1:0] fetch_pc,
  input  logic [`RV_XLEN-1:0] fetch_ir,
  input  logic                fetch_vld,
  output logic                fetch_rdy,
  // Write-back
  input  logic                regwr_en,
  input  regsel_t             regwr_sel,
  input  logic [`RV_XLEN-1:0] regwr_data,
  // Execute side
  input  logic                decode_rdy,
  output logic                decode_vld,
  output logic [`RV_XLEN-1:0] decode_pc,
  output logic [`RV_XLEN-1:0] decode_ir,
  output alu_op_e             decode_aluop,
  output logic [`RV_XLEN-1:0] decode_op1,
  output logic [`RV_XLEN-1:0] decode_op2,
  output logic                decode_regwr,
  output logic [`RV_XLEN-1:0] decode_addr,
  output logic [3:0]          decode_mask,
  output logic                decode_jump,
  output logic                decode_branch,
  output logic                decode_load,
  output logic                decode_store,
  output logic                decode_csr,
  output logic                decode_system,
  output sys_op_e             decode_sysop,
  output logic                decode_illegal,
  output logic                decode_misaligned_jmp,
  output logic                decode_misaligned_ldst
);

  logic [`RV_XLEN-1:0] rs1_data, rs2_data; // Already bypassed
  logic [`RV_XLEN-1:0] addr;
  logic                misaligned_jmp, misaligned_ldst, taken;

  reg_file u_reg_file (
    .clk       (clk),
    .rstz      (rstz),
    .rs1_sel   (fetch_ir[19:15]),
    .rs2_sel   (fetch_ir[24:20]),
    .regwr_en  (regwr_en),
    .regwr_sel (regwr_sel),
    .regwr_data(regwr_data),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data)
  );

  // ------------------------------
  // Address and branch paths, side by side
  addr_gen #(
    .CATCH_MISALIGNED_JMP (CATCH_MISALIGNED_JMP),
    .CATCH_MISALIGNED_LDST(CATCH_MISALIGNED_LDST)
  ) u_addr_gen (
    .instr          (fetch_ir),
    .pc             (fetch_pc),
    .rs1_data       (rs1_data),
    .addr           (addr),
    .misaligned_jmp (misaligned_jmp),
    .misaligned_ldst(misaligned_ldst)
  );

  branch_compare u_branch_compare (
    .instr   (fetch_ir),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .taken   (taken)
  );

  // ------------------------------
  // Decoder owns the output slot
  instr_decoder #(
    .CATCH_ILLEGAL_INSTR(CATCH_ILLEGAL_INSTR)
  ) u_instr_decoder (
    .clk                   (clk),
    .rstz                  (rstz),
    .flush                 (flush),
    .fetch_pc              (fetch_pc),
    .fetch_ir              (fetch_ir),
    .fetch_vld             (fetch_vld),
    .fetch_rdy             (fetch_rdy),
    .decode_rdy            (decode_rdy),
    .rs1_data              (rs1_data),
    .rs2_data              (rs2_data),
    .addr                  (addr),
    .misaligned_jmp        (misaligned_jmp),
    .misaligned_ldst       (misaligned_ldst),
    .taken                 (taken),
    .decode_vld            (decode_vld),
    .decode_pc             (decode_pc),
    .decode_ir             (decode_ir),
    .decode_aluop          (decode_aluop),
    .decode_op1            (decode_op1),
    .decode_op2            (decode_op2),
    .decode_regwr          (decode_regwr),
    .decode_addr           (decode_addr),
    .decode_mask           (decode_mask),
    .decode_jump           (decode_jump),
    .decode_branch         (decode_branch),
    .decode_load           (decode_load),
    .decode_store          (decode_store),
    .decode_csr            (decode_csr),
    .decode_system         (decode_system),
    .decode_sysop          (decode_sysop),
    .decode_illegal        (decode_illegal),
    .decode_misaligned_jmp (decode_misaligned_jmp),
    .decode_misaligned_ldst(decode_misaligned_ldst)
  );

endmodule

//--- testbench/decode_asserts.sv
/* Handshake and reset assertions, bound into the instruction decoder */

`timescale 1ns/1ps
`include "rv_consts.svh"

module decode_asserts (
  input logic                clk,
  input logic                rstz,
  input logic                flush,
  input logic                decode_rdy,
  input logic                decode_vld,
  input logic [`RV_XLEN-1:0] decode_pc,
  input logic [`RV_XLEN-1:0] decode_ir,
  input logic [`RV_XLEN-1:0] decode_op1,
  input logic [`RV_XLEN-1:0] decode_op2,
  input logic [`RV_XLEN-1:0] decode_addr,
  input logic [3:0]          decode_mask
);

  // Slot empty on the first edge out of reset
  reset_empty: assert property (@(posedge clk) $rose(rstz) |-> !decode_vld)
    else $error("decode_vld high on the first edge after reset");

  // Stalled slot keeps its contents
  hold_stable: assert property (@(posedge clk) disable iff (!rstz)
    decode_vld && !decode_rdy |=> $stable(decode_pc) && $stable(decode_ir)
      && $stable(decode_op1) && $stable(decode_op2) && $stable(decode_addr)
      && $stable(decode_mask))
    else $error("decode outputs changed under back-pressure");

  flush_clears: assert property (@(posedge clk) disable iff (!rstz) flush |=> !decode_vld)
    else $error("decode_vld high after a flush");

endmodule

bind instr_decoder decode_asserts u_decode_asserts (
  .clk        (clk),
  .rstz       (rstz),
  .flush      (flush),
  .decode_rdy (decode_rdy),
  .decode_vld (decode_vld),
  .decode_pc  (decode_pc),
  .decode_ir  (decode_ir),
  .decode_op1 (decode_op1),
  .decode_op2 (decode_op2),
  .decode_addr(decode_addr),
  .decode_mask(decode_mask)
);

//--- testbench/tb_decode_stage.sv
/* Decode stage testbench: clock, reset, directed tests per behavior,
   typed compare tasks and the closing verdict */

`timescale 1ns/1ps
`include "rv_consts.svh"

module tb_decode_stage
  import rv_isa_pkg::*;
  import rv_ex_pkg::*;
();

  localparam int WAIT_LIMIT = 20; // Cycles allowed per wait

  logic                clk;
  logic                rstz, flush;
  logic [`RV_XLEN-1:0] fetch_pc, fetch_ir;
  logic                fetch_vld, fetch_rdy;
  logic                regwr_en;
  regsel_t             regwr_sel;
  logic [`RV_XLEN-1:0] regwr_data;
  logic                decode_rdy, decode_vld;
  logic [`RV_XLEN-1:0] decode_pc, decode_ir, decode_op1, decode_op2, decode_addr;
  alu_op_e             decode_aluop;
  logic                decode_regwr;
  logic [3:0]          decode_mask;
  logic                decode_jump, decode_branch, decode_load, decode_store;
  logic                decode_csr, decode_system;
  sys_op_e             decode_sysop;
  logic                decode_illegal, decode_misaligned_jmp, decode_misaligned_ldst;

  logic [`RV_XLEN-1:0] model [`RV_NREGS]; // Values written through the port
  int                  errors, timeouts;
  bit                  hung;              // First timeout stops all further stimulus

  decode_stage UUT (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk; // 40 ns period
  end

  // ------------------------------
  // Instruction encoders, straight from the RV32I formats
  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input opcode_e opc);
    return {f7, rs2, rs1, f3, rd, opc, 2'b11};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input opcode_e opc);
    return {imm, rs1, f3, rd, opc, 2'b11};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], STORE, 2'b11};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], BRANCH, 2'b11};
  endfunction

  function automatic logic [31:0] sext12(input logic [11:0] imm);
    return {{20{imm[11]}}, imm};
  endfunction

  function automatic logic [31:0] sext13(input logic [12:0] imm);
    return {{19{imm[12]}}, imm};
  endfunction

  // Signed order by flipping the sign bits, then unsigned compare
  function automatic logic taken_ref(input logic [2:0] f3, input logic [31:0] a,
      input logic [31:0] b);
    logic lt_s, lt_u;
    lt_s = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
    lt_u = a < b;
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return lt_s;
      3'd5:    return !lt_s;
      3'd6:    return lt_u;
      3'd7:    return !lt_u;
      default: return 1'b0;
    endcase
  endfunction

  // ------------------------------
  // Compare tasks
  task automatic check_word(input string what, input logic [31:0] got,
      input logic [31:0] exp);
    if (!hung && got !== exp) begin
      errors++;
      $display("error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_aluop(input string what, input alu_op_e got, input alu_op_e exp);
    if (!hung && got !== exp) begin
      errors++;
      $display("error at %0d ns: %s is %s, expected %s", $time, what, got.name(), exp.name());
    end
  endtask

  task automatic check_sysop(input string what, input sys_op_e got, input sys_op_e exp);
    if (!hung && got !== exp) begin
      errors++;
      $display("error at %0d ns: %s is %s, expected %s", $time, what, got.name(), exp.name());
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (!hung && got !== exp) begin
      errors++;
      $display("error at %0d ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    hung = 1'b1;
    $display("Timed out after %0d cycles waiting for %s", WAIT_LIMIT, what);
  endtask

  // ------------------------------
  // Bus drivers, called and returning on a falling edge
  task automatic write_reg(input logic [4:0] sel, input logic [31:0] data);
    regwr_en   = 1'b1;
    regwr_sel  = sel;
    regwr_data = data;
    @(negedge clk);
    regwr_en = 1'b0;
    if (sel != 5'd0)
      model[sel] = data;
  endtask

  // Offer one instruction, then wait for it in the decode slot
  task automatic issue(input logic [31:0] pc, input logic [31:0] ir);
    int n;
    if (hung)
      return;
    n = 0;
    while (!fetch_rdy && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!fetch_rdy) begin
      report_timeout("fetch_rdy");
      return;
    end
    fetch_pc  = pc;
    fetch_ir  = ir;
    fetch_vld = 1'b1;
    @(negedge clk); // Accept edge
    fetch_vld = 1'b0;
    n = 0;
    while (!decode_vld && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!decode_vld)
      report_timeout("decode_vld");
  endtask

  // ------------------------------
  // Directed tests
  task automatic reset_handshake;
    logic [31:0] ir;
    ir = i_type(12'd5, 5'd0, 3'b000, 5'd1, OPIMM); // ADDI x1, x0, 5
    check_flag("decode_vld after reset", decode_vld, 1'b0);
    check_flag("fetch_rdy after reset", fetch_rdy, 1'b1);
    fetch_pc  = 32'h100;
    fetch_ir  = ir;
    fetch_vld = 1'b1;
    @(negedge clk); // Accept edge, slot filled one cycle later
    fetch_vld = 1'b0;
    check_flag("decode_vld one cycle after accept", decode_vld, 1'b1);
    check_word("ADDI pc", decode_pc, 32'h100);
    check_word("ADDI ir", decode_ir, ir);
    check_word("ADDI op2", decode_op2, 32'd5);
    decode_rdy = 1'b0; // Stall execute, offer the next one
    fetch_pc   = 32'h104;
    fetch_ir   = i_type(12'd9, 5'd0, 3'b000, 5'd1, OPIMM);
    fetch_vld  = 1'b1;
    @(negedge clk);
    check_flag("fetch_rdy under back-pressure", fetch_rdy, 1'b0);
    check_flag("decode_vld held", decode_vld, 1'b1);
    check_word("decode_pc held", decode_pc, 32'h100);
    check_word("decode_op2 held", decode_op2, 32'd5);
    flush      = 1'b1; // Offered instruction must be dropped
    decode_rdy = 1'b1;
    @(negedge clk);
    flush     = 1'b0;
    fetch_vld = 1'b0;
    check_flag("decode_vld after flush", decode_vld, 1'b0);
    check_word("decode_pc after flush", decode_pc, 32'h100);
    @(negedge clk);
  endtask

  task automatic alu_operands;
    logic [31:0] r;
    logic [19:0] u;
    for (int i = 1; i <= 4; i++) begin
      r = $urandom();
      write_reg(i[4:0], r);
    end
    issue(32'h200, r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd10, OP)); // ADD
    check_word("ADD op1", decode_op1, model[1]);
    check_word("ADD op2", decode_op2, model[2]);
    check_aluop("ADD aluop", decode_aluop, ADD);
    check_flag("ADD regwr", decode_regwr, 1'b1);
    check_flag("ADD illegal", decode_illegal, 1'b0);
    issue(32'h204, r_type(7'h20, 5'd4, 5'd3, 3'b000, 5'd10, OP)); // SUB
    check_word("SUB op1", decode_op1, model[3]);
    check_word("SUB op2", decode_op2, model[4]);
    check_aluop("SUB aluop", decode_aluop, SUB);
    issue(32'h208, i_type({7'h20, 5'd7}, 5'd3, 3'b101, 5'd10, OPIMM)); // SRAI by 7
    check_word("SRAI op1", decode_op1, model[3]);
    check_word("SRAI op2", decode_op2, sext12({7'h20, 5'd7}));
    check_aluop("SRAI aluop", decode_aluop, SRA);
    r = $urandom();
    u = r[31:12];
    issue(32'h20C, {u, 5'd10, LUI, 2'b11});
    check_word("LUI op1", decode_op1, 32'd0);
    check_word("LUI op2", decode_op2, {u, 12'b0});
    issue(32'h2340, {u, 5'd10, AUIPC, 2'b11});
    check_word("AUIPC op1", decode_op1, 32'h2340);
    check_word("AUIPC op2", decode_op2, {u, 12'b0});
    check_aluop("AUIPC aluop", decode_aluop, ADD);
  endtask

  task automatic forwarding;
    logic [31:0] d;
    d          = $urandom();
    regwr_en   = 1'b1; // Write x5 in the same cycle as the read
    regwr_sel  = 5'd5;
    regwr_data = d;
    issue(32'h300, i_type(12'd0, 5'd5, 3'b000, 5'd11, OPIMM));
    regwr_en = 1'b0;
    model[5] = d;
    check_word("x5 bypass to op1", decode_op1, d);
    regwr_en   = 1'b1; // x0 write must not bypass
    regwr_sel  = 5'd0;
    regwr_data = $urandom();
    issue(32'h304, i_type(12'd0, 5'd0, 3'b000, 5'd11, OPIMM));
    regwr_en = 1'b0;
    check_word("x0 read during x0 write", decode_op1, 32'd0);
  endtask

  task automatic branches_jumps;
    logic [31:0] a, b, pc, r, target;
    logic [12:0] off;
    logic [2:0]  f3;
    for (int pass = 0; pass < 2; pass++) begin // Second pass with equal operands
      for (int f = 0; f < 8; f++) begin
        if (f != 2 && f != 3) begin
          f3 = f[2:0];
          a  = $urandom();
          b  = (pass == 0) ? $urandom() : a;
          write_reg(5'd6, a);
          write_reg(5'd7, b);
          r      = $urandom();
          pc     = {r[31:2], 2'b00};
          r      = $urandom();
          off    = {r[12:1], 1'b0};
          target = pc + sext13(off);
          issue(pc, b_type(off, 5'd7, 5'd6, f3));
          check_flag($sformatf("branch f3=%0d taken", f3), decode_branch, taken_ref(f3, a, b));
          check_word($sformatf("branch f3=%0d target", f3), decode_addr, target);
          check_flag("branch misaligned", decode_misaligned_jmp, target[1]);
        end
      end
    end
    write_reg(5'd8, 32'h0000_1000);
    issue(32'h400, i_type(12'd3, 5'd8, 3'b000, 5'd1, JALR)); // Target 0x1003, bit 0 cleared
    check_word("JALR target", decode_addr, 32'h0000_1002);
    check_flag("JALR jump", decode_jump, 1'b1);
    check_flag("JALR misaligned", decode_misaligned_jmp, 1'b1);
    check_word("JALR link op1", decode_op1, 32'h400);
    check_word("JALR link op2", decode_op2, 32'd4);
    issue(32'h404, i_type(12'hFF9, 5'd8, 3'b000, 5'd1, JALR)); // 0x1000 - 7
    check_word("JALR back target", decode_addr, 32'h0000_0FF8);
    check_flag("JALR back misaligned", decode_misaligned_jmp, 1'b0);
  endtask

  task automatic stores_loads;
    logic [31:0] d;
    logic [3:0]  m;
    d = $urandom();
    write_reg(5'd9, 32'h0000_2000);
    write_reg(5'd12, d);
    for (int sz = 0; sz < 3; sz++) begin
      for (int off = 0; off < 4; off++) begin
        if (sz == 0)
          m = 4'b0001 << off;
        else if (sz == 1)
          m = (off >= 2) ? 4'b1100 : 4'b0011;
        else
          m = 4'b1111;
        issue(32'h500, s_type(off[11:0], 5'd12, 5'd9, sz[2:0]));
        check_word($sformatf("store sz=%0d off=%0d mask", sz, off), {28'b0, decode_mask},
                   {28'b0, m});
        check_word("store data", decode_op2, (d << (8 * off)) | (d >> (32 - 8 * off)));
        check_word("store addr", decode_addr, 32'h2000 + off);
        check_flag("store flag", decode_store, 1'b1);
        check_flag("store misaligned", decode_misaligned_ldst,
                   (sz == 1 && off[0]) || (sz == 2 && off != 0));
      end
    end
    issue(32'h600, i_type(12'd1, 5'd9, 3'b001, 5'd13, LOAD)); // LH odd
    check_flag("LH load flag", decode_load, 1'b1);
    check_flag("LH misaligned", decode_misaligned_ldst, 1'b1);
    issue(32'h604, i_type(12'd2, 5'd9, 3'b010, 5'd13, LOAD)); // LW on half boundary
    check_flag("LW misaligned", decode_misaligned_ldst, 1'b1);
    issue(32'h608, i_type(12'd4, 5'd9, 3'b010, 5'd13, LOAD));
    check_word("LW addr", decode_addr, 32'h0000_2004);
    check_flag("LW aligned", decode_misaligned_ldst, 1'b0);
  endtask

  task automatic illegal_system;
    logic [11:0] f12 [4];
    sys_op_e     ops [4];
    f12 = '{12'h000, 12'h001, 12'h302, 12'h105}; // ECALL EBREAK MRET WFI
    ops = '{ECALL, EBREAK, MRET, WFI};
    issue(32'h700, r_type(7'h01, 5'd2, 5'd1, 3'b000, 5'd10, OP)); // MUL, not RV32I
    check_flag("OP funct7 illegal", decode_illegal, 1'b1);
    issue(32'h704, r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd10, OP) & 32'hFFFF_FFFD);
    check_flag("compressed bits illegal", decode_illegal, 1'b1);
    for (int k = 0; k < 4; k++) begin
      issue(32'h708, i_type(f12[k], 5'd0, 3'b000, 5'd0, SYSTEM));
      check_flag("system flag", decode_system, 1'b1);
      check_flag("system csr", decode_csr, 1'b0);
      check_flag("system illegal", decode_illegal, 1'b0);
      check_sysop("sysop", decode_sysop, ops[k]);
    end
    issue(32'h70C, i_type(12'h300, 5'd2, 3'b001, 5'd1, SYSTEM)); // CSRRW x1, mstatus, x2
    check_flag("CSRRW csr", decode_csr, 1'b1);
    check_flag("CSRRW system", decode_system, 1'b0);
    check_flag("CSRRW illegal", decode_illegal, 1'b0);
  endtask

  // ------------------------------
  initial begin
    void'($urandom(59));
    rstz       = 1'b0;
    flush      = 1'b0;
    fetch_pc   = '0;
    fetch_ir   = 32'h0000_0013; // NOP
    fetch_vld  = 1'b0;
    regwr_en   = 1'b0;
    regwr_sel  = '0;
    regwr_data = '0;
    decode_rdy = 1'b1;
    errors     = 0;
    timeouts   = 0;
    hung       = 1'b0;
    for (int i = 0; i < `RV_NREGS; i++)
      model[i] = '0;
    repeat (16) @(negedge clk);
    rstz = 1'b1;

    reset_handshake();
    alu_operands();
    forwarding();
    branches_jumps();
    stores_loads();
    illegal_system();

    $display("Decode stage run done: %0d value errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- sim.f
+incdir+common
common/rv_isa_pkg.sv
common/rv_ex_pkg.sv
rtl/reg_file.sv
rtl/addr_gen.sv
rtl/branch_compare.sv
decode/instr_decoder.sv
decode/decode_stage.sv
testbench/decode_asserts.sv
testbench/tb_decode_stage.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the decode stage testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_decode_stage -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vtb_decode_stage)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qxF "** PASS **"; then
  exit 0
fi
exit 1
